/* sim.f */
+incdir+sim
rtl/recorder_pkg.sv
rtl/window_ram.sv
rtl/window_capture.sv
rtl/block_sequencer.sv
rtl/record_emitter.sv
rtl/window_recorder.sv
sim/tb_window_recorder.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing --timescale 1ns/1ps
TOP       := tb_window_recorder
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// reference model of the window, fed with accepted writes only
logic [RECORD_W-1:0]     model_mem [WINDOW_DEPTH];
logic [WINDOW_DEPTH-1:0] model_tags;
logic [WINDOW_PTR_W-1:0] model_ptr;
int                      model_run;
bit                      model_armed;
// records already started in the open block
int                      model_blk;

task automatic report_mismatch(input string what, input logic [RECORD_W-1:0] expected,
		input logic [RECORD_W-1:0] actual);
	check_fail_cnt++;
	$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
endtask

task automatic report_problem(input string msg);
	check_fail_cnt++;
	$display("%s: %s", test_name, msg);
endtask

task automatic apply_reset();
	@(posedge clk);
	#DRIVE_DLY;
	rst_n       = 1'b0;
	rec_wen_i   = 1'b0;
	rec_data_i  = '0;
	rec_tag_i   = 1'b0;
	out_ready_i = 1'b1;
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DLY;
	rst_n = 1'b1;
	// ram has no reset, slots unknown until written
	model_mem   = '{default: 'x};
	model_tags  = '0;
	model_ptr   = '0;
	model_run   = 0;
	model_armed = 1'b0;
	model_blk   = 0;
endtask

task automatic start_test(input string name);
	test_name      = name;
	fails_at_start = check_fail_cnt;
	apply_reset();
endtask

task automatic finish_test();
	int failed;
	failed = check_fail_cnt - fails_at_start;
	test_cnt++;
	if (failed == 0)
	begin
		$display("%s: ok", test_name);
	end
	else
	begin
		test_fail_cnt++;
		$display("%s: %0d checks failed", test_name, failed);
	end
endtask

// one strobe cycle, sampled by the second edge
task automatic pulse_write(input logic [RECORD_W-1:0] data, input logic tag);
	@(posedge clk);
	#DRIVE_DLY;
	rec_wen_i  = 1'b1;
	rec_data_i = data;
	rec_tag_i  = tag;
	@(posedge clk);
	#DRIVE_DLY;
	rec_wen_i  = 1'b0;
endtask

// window rules for one accepted write
task automatic model_accept(input logic [RECORD_W-1:0] data, input bit tag, output bit emit,
		output logic [RECORD_W-1:0] exp_data, output bit exp_last);
	// arm on the write that finds WINDOW_DEPTH-1 in the run counter
	if (!tag)
		model_run = 0;
	else if (model_run == WINDOW_DEPTH - 1)
		model_armed = 1'b1;
	else
		model_run++;
	model_mem[model_ptr]  = data;
	model_tags[model_ptr] = tag;
	if (model_ptr == WINDOW_PTR_W'(WINDOW_DEPTH - 1))
		model_ptr = '0;
	else
		model_ptr = model_ptr + 1'b1;
	// next slot holds the oldest record
	emit     = model_armed;
	exp_data = model_mem[model_ptr];
	exp_last = (model_blk == BLOCK_DEPTH - 1);
	if (emit)
		model_blk = exp_last ? 0 : model_blk + 1;
endtask

// waits for the valid pulse and compares the record
task automatic expect_record(input logic [RECORD_W-1:0] exp_data, input bit exp_last,
		output int latency);
	bit seen;
	latency = 0;
	seen    = 1'b0;
	while (!seen && latency < 20)
	begin
		@(posedge clk);
		#DRIVE_DLY;
		latency++;
		seen = out_valid_o;
	end
	if (!seen)
	begin
		report_problem("no output record appeared within 20 cycles");
	end
	else
	begin
		if (out_data_o !== exp_data)
			report_mismatch("out_data_o", exp_data, out_data_o);
		if (out_last_o !== exp_last)
			report_mismatch("out_last_o", RECORD_W'(exp_last), RECORD_W'(out_last_o));
	end
endtask

// gap and ready wait, block done expected 4 cycles after a last record
task automatic follow_record(input bit last);
	int n;
	n = last ? 5 : 3;
	for (int i = 1; i <= n; i++)
	begin
		@(posedge clk);
		#DRIVE_DLY;
		if (out_valid_o !== 1'b0)
			report_mismatch("out_valid_o", '0, RECORD_W'(out_valid_o));
		if (block_done_o !== (last && i == 4))
			report_mismatch("block_done_o", RECORD_W'(last && i == 4), RECORD_W'(block_done_o));
	end
endtask

task automatic quiet_cycles(input int n);
	repeat (n)
	begin
		@(posedge clk);
		#DRIVE_DLY;
		if (out_valid_o !== 1'b0 || block_done_o !== 1'b0)
			report_problem("output strobe seen while none was expected");
	end
endtask

// invalid window with an open block, rest of the block comes as fill
task automatic expect_padding();
	int latency;
	bit last;
	bit first;
	if (model_tags == '0)
	begin
		first = 1'b1;
		while (model_blk != 0)
		begin
			last      = (model_blk == BLOCK_DEPTH - 1);
			model_blk = last ? 0 : model_blk + 1;
			expect_record(PAD_RECORD, last, latency);
			// back to back pads, one per ready wait
			if (!first && latency != 1)
				report_mismatch("pad spacing", 1, latency);
			first = 1'b0;
			follow_record(last);
		end
		model_armed = 1'b0;
		model_run   = 0;
	end
endtask

task automatic write_record(input bit tag);
	logic [RECORD_W-1:0] data;
	logic [RECORD_W-1:0] exp_data;
	bit                  exp_last;
	bit                  emit;
	int                  latency;
	data = $urandom();
	// keep real records apart from fill
	if (data == PAD_RECORD)
		data = '0;
	pulse_write(data, tag);
	model_accept(data, tag, emit, exp_data, exp_last);
	if (window_flags_o !== model_tags)
		report_mismatch("window_flags_o", RECORD_W'(model_tags), RECORD_W'(window_flags_o));
	if (emit)
	begin
		expect_record(exp_data, exp_last, latency);
		if (latency != 4)
			report_mismatch("valid latency", 4, latency);
		follow_record(exp_last);
	end
	else
	begin
		quiet_cycles(6);
	end
	expect_padding();
endtask

task automatic reset_state_test();
	start_test("reset_state");
	if (out_valid_o !== 1'b0)
		report_mismatch("out_valid_o", '0, RECORD_W'(out_valid_o));
	if (out_last_o !== 1'b0)
		report_mismatch("out_last_o", '0, RECORD_W'(out_last_o));
	if (block_done_o !== 1'b0)
		report_mismatch("block_done_o", '0, RECORD_W'(block_done_o));
	if (window_flags_o !== '0)
		report_mismatch("window_flags_o", '0, RECORD_W'(window_flags_o));
	// one short of arming
	repeat (WINDOW_DEPTH - 1) write_record(1'b1);
	finish_test();
endtask

task automatic arming_order_test();
	start_test("arming_order");
	repeat (WINDOW_DEPTH) write_record(1'b1);
	// armed window keeps emitting on an untagged write
	write_record(1'b0);
	repeat (4) write_record(1'b1);
	finish_test();
endtask

task automatic broken_run_test();
	start_test("broken_run");
	repeat (5) write_record(1'b1);
	write_record(1'b0);
	// count restarts here
	repeat (WINDOW_DEPTH) write_record(1'b1);
	finish_test();
endtask

task automatic break_padding_test();
	int done_before;
	start_test("break_padding");
	done_before = done_pulse_cnt;
	// 5 records into the block
	repeat (WINDOW_DEPTH + 4) write_record(1'b1);
	// window drains to all untagged, fill follows
	repeat (WINDOW_DEPTH) write_record(1'b0);
	if (done_pulse_cnt != done_before + 1)
		report_mismatch("block_done pulses", 1, done_pulse_cnt - done_before);
	// disarmed now
	write_record(1'b1);
	finish_test();
endtask

task automatic full_block_test();
	int done_before;
	start_test("full_block");
	done_before = done_pulse_cnt;
	repeat (WINDOW_DEPTH - 1 + BLOCK_DEPTH) write_record(1'b1);
	if (done_pulse_cnt != done_before + 1)
		report_mismatch("block_done pulses", 1, done_pulse_cnt - done_before);
	// first record of the next block
	write_record(1'b1);
	finish_test();
endtask

task automatic back_pressure_test();
	logic [WINDOW_DEPTH-1:0] flags_held;
	start_test("back_pressure");
	repeat (WINDOW_DEPTH - 1) write_record(1'b1);
	out_ready_i = 1'b0;
	write_record(1'b1);
	flags_held = window_flags_o;
	// sequencer busy, these strobes are lost
	repeat (3) pulse_write($urandom(), 1'b0);
	quiet_cycles(10);
	if (window_flags_o !== flags_held)
		report_mismatch("window_flags_o", RECORD_W'(flags_held), RECORD_W'(window_flags_o));
	out_ready_i = 1'b1;
	repeat (3) write_record(1'b1);
	finish_test();
endtask

`endif

/* sim/tb_window_recorder.sv */
module tb_window_recorder
	import recorder_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned SEED = 32'h4255_016d;
	localparam int HALF_PERIOD  = 50;
	// inputs change this long after the rising edge, outputs are read there too
	localparam int DRIVE_DLY    = 10;
	localparam int RESET_CYCLES = 16;
	// 6 tests, up to 40 records each, about 25 cycles per record
	localparam int TIMEOUT_CYCLES = 6 * 40 * 25;

	logic                    clk;
	logic                    rst_n;
	logic                    rec_wen_i;
	logic [RECORD_W-1:0]     rec_data_i;
	logic                    rec_tag_i;
	logic [WINDOW_DEPTH-1:0] window_flags_o;
	logic                    out_valid_o;
	logic [RECORD_W-1:0]     out_data_o;
	logic                    out_last_o;
	logic                    out_ready_i;
	logic                    block_done_o;

	// run bookkeeping
	int    cycle_cnt      = 0;
	int    check_fail_cnt = 0;
	int    test_cnt       = 0;
	int    test_fail_cnt  = 0;
	int    done_pulse_cnt = 0;
	int    fails_at_start = 0;
	string test_name      = "";

	window_recorder DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.rec_wen_i      (rec_wen_i),
		.rec_data_i     (rec_data_i),
		.rec_tag_i      (rec_tag_i),
		.window_flags_o (window_flags_o),
		.out_valid_o    (out_valid_o),
		.out_data_o     (out_data_o),
		.out_last_o     (out_last_o),
		.out_ready_i    (out_ready_i),
		.block_done_o   (block_done_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// cycle count for the watchdog, block done pulses seen at each edge
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (block_done_o)
			done_pulse_cnt <= done_pulse_cnt + 1;
	end

`include "tb_tests.svh"

	// watchdog
	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		rst_n       = 1'b0;
		rec_wen_i   = 1'b0;
		rec_data_i  = '0;
		rec_tag_i   = 1'b0;
		out_ready_i = 1'b1;
		void'($urandom(SEED));
		reset_state_test();
		arming_order_test();
		broken_run_test();
		break_padding_test();
		full_block_test();
		back_pressure_test();
		$display("tests run %0d, tests with errors %0d, checks failed %0d",
			test_cnt, test_fail_cnt, check_fail_cnt);
		if (check_fail_cnt == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* rtl/window_recorder.sv */
module window_recorder
	import recorder_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	// record input
	input  logic                    rec_wen_i,
	input  logic [RECORD_W-1:0]     rec_data_i,
	input  logic                    rec_tag_i,
	// tags of the window slots
	output logic [WINDOW_DEPTH-1:0] window_flags_o,
	// record output
	output logic                    out_valid_o,
	output logic [RECORD_W-1:0]     out_data_o,
	output logic                    out_last_o,
	input  logic                    out_ready_i,
	output logic                    block_done_o
);

	// capture to ram
	logic                    ram_wen;
	logic [WINDOW_PTR_W-1:0] ram_waddr;
	logic [RECORD_W-1:0]     ram_wdata;
	// sequencer to ram, ram to emitter
	logic [WINDOW_PTR_W-1:0] ram_raddr;
	logic [RECORD_W-1:0]     ram_rdata;
	// capture and sequencer handshake
	logic                    armed;
	logic                    wrote_last_cycle;
	logic                    window_empty_valid;
	logic [WINDOW_PTR_W-1:0] oldest_ptr;
	logic                    capture_en;
	logic                    disarm;
	// sequencer and emitter handshake
	logic                    emit_req;
	logic                    emit_pad;
	logic                    emit_last;
	logic                    emit_done;

	window_capture u_capture (
		.clk                  (clk),
		.rst_n                (rst_n),
		.rec_wen_i            (rec_wen_i),
		.rec_data_i           (rec_data_i),
		.rec_tag_i            (rec_tag_i),
		.capture_en_i         (capture_en),
		.disarm_i             (disarm),
		.ram_wen_o            (ram_wen),
		.ram_waddr_o          (ram_waddr),
		.ram_wdata_o          (ram_wdata),
		.oldest_ptr_o         (oldest_ptr),
		.armed_o              (armed),
		.wrote_last_cycle_o   (wrote_last_cycle),
		.window_empty_valid_o (window_empty_valid),
		.window_flags_o       (window_flags_o)
	);

	window_ram #(
		.DATA_W (RECORD_W)
	) u_ram (
		.clk     (clk),
		.wen_i   (ram_wen),
		.waddr_i (ram_waddr),
		.wdata_i (ram_wdata),
		.raddr_i (ram_raddr),
		.rdata_o (ram_rdata)
	);

	block_sequencer u_sequencer (
		.clk                  (clk),
		.rst_n                (rst_n),
		.armed_i              (armed),
		.wrote_last_cycle_i   (wrote_last_cycle),
		.window_empty_valid_i (window_empty_valid),
		.oldest_ptr_i         (oldest_ptr),
		.emit_done_i          (emit_done),
		.capture_en_o         (capture_en),
		.disarm_o             (disarm),
		.ram_raddr_o          (ram_raddr),
		.emit_req_o           (emit_req),
		.emit_pad_o           (emit_pad),
		.emit_last_o          (emit_last),
		.block_done_o         (block_done_o)
	);

	record_emitter u_emitter (
		.clk         (clk),
		.rst_n       (rst_n),
		.emit_req_i  (emit_req),
		.emit_pad_i  (emit_pad),
		.emit_last_i (emit_last),
		.ram_rdata_i (ram_rdata),
		.out_ready_i (out_ready_i),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o),
		.out_last_o  (out_last_o),
		.emit_done_o (emit_done)
	);

endmodule

/* rtl/record_emitter.sv */
module record_emitter
	import recorder_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	// request from the sequencer
	input  logic                emit_req_i,
	input  logic                emit_pad_i,
	input  logic                emit_last_i,
	// registered window ram data
	input  logic [RECORD_W-1:0] ram_rdata_i,
	// output strobe side
	input  logic                out_ready_i,
	output logic                out_valid_o,
	output logic [RECORD_W-1:0] out_data_o,
	output logic                out_last_o,
	output logic                emit_done_o
);

	typedef enum logic [1:0] {
		E_IDLE,
		E_VALID,
		E_GAP,
		E_WAIT
	} emit_phase_t;

	emit_phase_t phase;
	logic        launch;

	assign launch = (phase == E_IDLE) && emit_req_i;

	// ready wait ends in the cycle ready is seen
	assign emit_done_o = (phase == E_WAIT) && out_ready_i;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase       <= E_IDLE;
			out_valid_o <= 1'b0;
			out_last_o  <= 1'b0;
		end
		else
		begin
			case (phase)
				E_IDLE:
				begin
					if (launch)
					begin
						phase       <= E_VALID;
						out_valid_o <= 1'b1;
						out_last_o  <= emit_last_i;
					end
				end
				E_VALID:
				begin
					// valid and last are one cycle wide
					phase       <= E_GAP;
					out_valid_o <= 1'b0;
					out_last_o  <= 1'b0;
				end
				E_GAP:
				begin
					phase <= E_WAIT;
				end
				E_WAIT:
				begin
					// ready is a level, polled every cycle
					if (out_ready_i)
						phase <= E_IDLE;
				end
				default:
				begin
					phase <= E_IDLE;
				end
			endcase
		end
	end

	// payload held until the next launch
	always_ff @(posedge clk)
	begin
		if (launch)
			out_data_o <= emit_pad_i ? PAD_RECORD : ram_rdata_i;
	end

endmodule

/* rtl/block_sequencer.sv */
module block_sequencer
	import recorder_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	// window status
	input  logic                    armed_i,
	input  logic                    wrote_last_cycle_i,
	input  logic                    window_empty_valid_i,
	input  logic [WINDOW_PTR_W-1:0] oldest_ptr_i,
	// end of the ready wait
	input  logic                    emit_done_i,
	// back to the capture side
	output logic                    capture_en_o,
	output logic                    disarm_o,
	// window ram read address
	output logic [WINDOW_PTR_W-1:0] ram_raddr_o,
	// request to the emitter
	output logic                    emit_req_o,
	output logic                    emit_pad_o,
	output logic                    emit_last_o,
	output logic                    block_done_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_EMIT,
		S_PAD,
		S_CLOSE,
		S_DONE
	} seq_state_t;

	localparam logic [BLOCK_CNT_W-1:0] LAST_IN_BLOCK = BLOCK_CNT_W'(BLOCK_DEPTH - 1);

	seq_state_t             state;
	// second read cycle flag
	logic                   read_wait;
	// records started in the open block, zero means no block open
	logic [BLOCK_CNT_W-1:0] blk_cnt;
	logic                   block_open;
	logic                   at_last;
	logic                   start_emit;
	logic                   break_seen;

	assign block_open = (blk_cnt != '0);
	// next record started closes the block
	assign at_last    = (blk_cnt == LAST_IN_BLOCK);

	// a write landed last cycle on an armed window
	assign start_emit = (state == S_IDLE) && wrote_last_cycle_i && armed_i;
	// quiet idle cycle with nothing tagged in the window
	assign break_seen = (state == S_IDLE) && !wrote_last_cycle_i && window_empty_valid_i;

	// writes only accepted while idle
	assign capture_en_o = (state == S_IDLE);
	assign disarm_o     = break_seen;
	assign block_done_o = (state == S_DONE);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state       <= S_IDLE;
			read_wait   <= 1'b0;
			blk_cnt     <= '0;
			ram_raddr_o <= '0;
			emit_req_o  <= 1'b0;
			emit_pad_o  <= 1'b0;
			emit_last_o <= 1'b0;
		end
		else
		begin
			// request is a single cycle pulse
			emit_req_o <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start_emit)
					begin
						// fetch the oldest record
						state       <= S_READ;
						ram_raddr_o <= oldest_ptr_i;
						read_wait   <= 1'b0;
						emit_pad_o  <= 1'b0;
						emit_last_o <= at_last;
						blk_cnt     <= blk_cnt + 1'b1;
					end
					else if (break_seen && block_open)
					begin
						// pad out the rest of the open block
						state       <= S_PAD;
						emit_req_o  <= 1'b1;
						emit_pad_o  <= 1'b1;
						emit_last_o <= at_last;
						blk_cnt     <= blk_cnt + 1'b1;
					end
				end
				S_READ:
				begin
					// address cycle, then ram data cycle
					if (read_wait)
					begin
						state      <= S_EMIT;
						emit_req_o <= 1'b1;
					end
					else
					begin
						read_wait <= 1'b1;
					end
				end
				S_EMIT:
				begin
					if (emit_done_i)
						state <= emit_last_o ? S_CLOSE : S_IDLE;
				end
				S_PAD:
				begin
					if (emit_done_i)
					begin
						if (emit_last_o)
						begin
							state <= S_CLOSE;
						end
						else
						begin
							// one pad record per ready wait
							emit_req_o  <= 1'b1;
							emit_last_o <= at_last;
							blk_cnt     <= blk_cnt + 1'b1;
						end
					end
				end
				S_CLOSE:
				begin
					// block finished, counter back to closed
					blk_cnt <= '0;
					state   <= S_DONE;
				end
				S_DONE:
				begin
					state <= S_IDLE;
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

/* rtl/window_capture.sv */
module window_capture
	import recorder_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	// record input strobe
	input  logic                    rec_wen_i,
	input  logic [RECORD_W-1:0]     rec_data_i,
	input  logic                    rec_tag_i,
	// control from the sequencer
	input  logic                    capture_en_i,
	input  logic                    disarm_i,
	// window ram write port
	output logic                    ram_wen_o,
	output logic [WINDOW_PTR_W-1:0] ram_waddr_o,
	output logic [RECORD_W-1:0]     ram_wdata_o,
	// status to the sequencer
	output logic [WINDOW_PTR_W-1:0] oldest_ptr_o,
	output logic                    armed_o,
	output logic                    wrote_last_cycle_o,
	output logic                    window_empty_valid_o,
	output logic [WINDOW_DEPTH-1:0] window_flags_o
);

	localparam logic [WINDOW_PTR_W-1:0] LAST_SLOT = WINDOW_PTR_W'(WINDOW_DEPTH - 1);

	// strobes outside the idle state are simply lost
	logic                    take;
	logic [WINDOW_PTR_W-1:0] wr_ptr;
	logic [WINDOW_DEPTH-1:0] tags;
	// consecutive tagged writes, saturates at LAST_SLOT
	logic [WINDOW_PTR_W-1:0] run_cnt;
	logic                    armed;
	logic                    wrote_q;

	assign take = rec_wen_i & capture_en_i;

	// record goes straight into the slot under the pointer
	assign ram_wen_o   = take;
	assign ram_waddr_o = wr_ptr;
	assign ram_wdata_o = rec_data_i;

	// next slot to write still holds the oldest record
	assign oldest_ptr_o         = wr_ptr;
	assign armed_o              = armed;
	assign wrote_last_cycle_o   = wrote_q;
	assign window_flags_o       = tags;
	// no tagged record left anywhere in the window
	assign window_empty_valid_o = ~|tags;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr  <= '0;
			tags    <= '0;
			run_cnt <= '0;
			armed   <= 1'b0;
			wrote_q <= 1'b0;
		end
		else
		begin
			wrote_q <= take;
			if (take)
			begin
				tags[wr_ptr] <= rec_tag_i;
				// circular pointer
				if (wr_ptr == LAST_SLOT)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
				if (disarm_i)
				begin
					// a new run may start on this very write
					armed   <= 1'b0;
					run_cnt <= rec_tag_i ? WINDOW_PTR_W'(1) : '0;
				end
				else if (!rec_tag_i)
				begin
					// untagged write breaks the run
					run_cnt <= '0;
				end
				else if (run_cnt == LAST_SLOT)
				begin
					// window now full of a tagged run
					armed <= 1'b1;
				end
				else
				begin
					run_cnt <= run_cnt + 1'b1;
				end
			end
			else if (disarm_i)
			begin
				armed   <= 1'b0;
				run_cnt <= '0;
			end
		end
	end

endmodule

/* rtl/window_ram.sv */
module window_ram
	import recorder_pkg::*;
#(
	parameter int DATA_W = RECORD_W
)
(
	input  logic                    clk,
	input  logic                    wen_i,
	input  logic [WINDOW_PTR_W-1:0] waddr_i,
	input  logic [DATA_W-1:0]       wdata_i,
	input  logic [WINDOW_PTR_W-1:0] raddr_i,
	output logic [DATA_W-1:0]       rdata_o
);

	// one slot per window position
	logic [DATA_W-1:0] mem [WINDOW_DEPTH];

	// write port and registered read port share the clock
	// read of the slot being written returns the old word
	always_ff @(posedge clk)
	begin
		if (wen_i)
		begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

endmodule

/* rtl/recorder_pkg.sv */
package recorder_pkg;

	// window geometry
	// records kept in the circular window
	localparam int WINDOW_DEPTH = 8;
	// one slot address
	localparam int WINDOW_PTR_W = 3;

	// record payload width, tag travels beside it
	localparam int RECORD_W = 32;

	// block geometry
	// four windows per block
	localparam int BLOCK_DEPTH = 4 * WINDOW_DEPTH;
	// holds 0 up to BLOCK_DEPTH
	localparam int BLOCK_CNT_W = 6;

	// filler used when a broken block is padded out
	localparam logic [RECORD_W-1:0] PAD_RECORD = {RECORD_W{1'b1}};

endpackage
